// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_conv_layer
FILE_LIST = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test FAILED

SOURCES := $(filter %.sv,$(shell cat $(FILE_LIST))) tb_conv_tests.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== conv_control.sv ====
`timescale 1ns/1ps

module conv_control #(
    parameter int IFM_SIZE          = 6,
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int OUT_SIZE = IFM_SIZE - KERNEL_SIZE + 1,
    localparam int MAP      = OUT_SIZE * OUT_SIZE,
    localparam int PIX      = IFM_SIZE * IFM_SIZE,
    localparam int IFM_AW   = $clog2(IFM_DEPTH * PIX),
    localparam int OUT_AW   = $clog2(NUMBER_OF_FILTERS * MAP),
    localparam int FILT_W   = $clog2(NUMBER_OF_FILTERS),
    localparam int CH_W     = $clog2(IFM_DEPTH)
)(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic              busy,
    output logic              ifm_read_en,
    output logic [IFM_AW-1:0] ifm_read_addr,
    output logic              window_valid,
    output logic [FILT_W-1:0] filter_index,
    output logic [CH_W-1:0]   channel_index,
    output logic              out_write_en,
    output logic [OUT_AW-1:0] out_write_addr,
    output logic              out_accumulate,
    output logic              out_relu
);

    localparam logic [1:0] S_IDLE  = 2'd0,
                           S_READ  = 2'd1,
                           S_GAP   = 2'd2,
                           S_DRAIN = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;
    logic [$clog2(PIX)-1:0] pixel_counter;
    logic [$clog2(IFM_SIZE)-1:0] col;
    logic [$clog2(IFM_SIZE)-1:0] row;
    logic [$clog2(MAP)-1:0] out_pos;
    logic [FILT_W-1:0] filter_counter;
    logic [CH_W-1:0] depth_counter;
    logic [1:0] drain_counter;
    logic pass_end;
    logic last_pass;
    logic win_now;
    logic [2:0] valid_d;
    logic [2:0] acc_d;
    logic [2:0] relu_d;
    logic [OUT_AW-1:0] addr_d [3];

    assign pass_end  = (state == S_READ) && (pixel_counter == PIX - 1);
    assign last_pass = (filter_counter == NUMBER_OF_FILTERS - 1)
                       && (depth_counter == IFM_DEPTH - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= S_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:
                if (start)
                    state_next = S_READ;
            S_READ:
                if (pass_end)
                    state_next = last_pass ? S_DRAIN : S_GAP;
            S_GAP:
                state_next = S_READ;
            default:  // drain the write pipeline
                if (drain_counter == 2'd2)
                    state_next = S_IDLE;
        endcase
    end

    assign busy          = (state != S_IDLE);
    assign ifm_read_en   = (state == S_READ);
    assign ifm_read_addr = IFM_AW'(depth_counter * PIX + pixel_counter);

    // lower-right pixel of a full window is being read
    assign win_now = ifm_read_en && (row >= KERNEL_SIZE - 1) && (col >= KERNEL_SIZE - 1);

    ////////////////////////////////////////////////////////////
    // pass counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pixel_counter  <= '0;
            col            <= '0;
            row            <= '0;
            out_pos        <= '0;
            filter_counter <= '0;
            depth_counter  <= '0;
            drain_counter  <= '0;
        end
        else
        begin
            if (pass_end)
            begin
                pixel_counter <= '0;
                col           <= '0;
                row           <= '0;
                out_pos       <= '0;
                if (filter_counter == NUMBER_OF_FILTERS - 1)
                begin
                    filter_counter <= '0;
                    depth_counter  <= last_pass ? '0 : depth_counter + 1'b1;
                end
                else
                    filter_counter <= filter_counter + 1'b1;
            end
            else if (ifm_read_en)
            begin
                pixel_counter <= pixel_counter + 1'b1;
                if (col == IFM_SIZE - 1)
                begin
                    col <= '0;
                    row <= row + 1'b1;
                end
                else
                    col <= col + 1'b1;
                if (win_now)
                    out_pos <= out_pos + 1'b1;
            end
            drain_counter <= (state == S_DRAIN) ? drain_counter + 1'b1 : 2'd0;
        end
    end

    ////////////////////////////////////////////////////////////
    // delay chain so the write lines up with the MAC sum
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            valid_d       <= '0;
            acc_d         <= '0;
            relu_d        <= '0;
            filter_index  <= '0;
            channel_index <= '0;
        end
        else
        begin
            valid_d       <= {valid_d[1:0], win_now};
            acc_d         <= {acc_d[1:0], depth_counter != 0};
            relu_d        <= {relu_d[1:0], depth_counter == IFM_DEPTH - 1};
            filter_index  <= filter_counter;  // aligned with window
            channel_index <= depth_counter;
        end
    end

    always_ff @(posedge clk)
    begin
        addr_d[0] <= OUT_AW'(filter_counter * MAP + out_pos);
        addr_d[1] <= addr_d[0];
        addr_d[2] <= addr_d[1];
    end

    assign window_valid   = valid_d[0];
    assign out_write_en   = valid_d[2];
    assign out_accumulate = acc_d[2];
    assign out_relu       = relu_d[2];
    assign out_write_addr = addr_d[2];

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        !busy |-> !out_write_en);
    // each pass ends on the last window of a full map
    a_window_count: assert property (@(posedge clk) disable iff (reset)
        pass_end |-> win_now && (out_pos == MAP - 1));

endmodule

// ==== conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top #(
    parameter int IFM_SIZE          = 6,
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2
)(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [conv_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
    input  logic [conv_pkg::WB_WIDTH-1:0]       wb_dat_w,
    input  logic [conv_pkg::WB_WIDTH/8-1:0]     wb_sel,
    output logic [conv_pkg::WB_WIDTH-1:0]       wb_dat_r,
    output logic                                wb_ack
);

    localparam int OUT_SIZE = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int IFM_AW   = $clog2(IFM_DEPTH * IFM_SIZE * IFM_SIZE);
    localparam int W_IDX_W  = $clog2(NUMBER_OF_FILTERS * IFM_DEPTH * KERNEL_SIZE * KERNEL_SIZE);
    localparam int FILT_W   = $clog2(NUMBER_OF_FILTERS);
    localparam int CH_W     = $clog2(IFM_DEPTH);
    localparam int OUT_AW   = $clog2(NUMBER_OF_FILTERS * OUT_SIZE * OUT_SIZE);
    localparam int DW       = conv_pkg::DATA_WIDTH;
    localparam int ACC      = conv_pkg::ACC_WIDTH;

    logic start;
    logic busy;
    logic ifm_read_en;
    logic [IFM_AW-1:0] ifm_read_addr;
    logic [DW-1:0] pixel;
    logic pixel_valid;
    logic [KERNEL_SIZE*KERNEL_SIZE*DW-1:0] window;
    logic [FILT_W-1:0] filter_index;
    logic [CH_W-1:0] channel_index;
    logic weight_write_en;
    logic [W_IDX_W-1:0] weight_write_index;
    logic [DW-1:0] weight_write_data;
    logic bias_write_en;
    logic [FILT_W-1:0] bias_write_index;
    logic [ACC-1:0] bias_write_data;
    logic out_write_en;
    logic [OUT_AW-1:0] out_write_addr;
    logic out_accumulate;
    logic out_relu;
    logic [OUT_AW-1:0] out_read_addr;
    logic signed [ACC-1:0] sum;
    logic signed [ACC-1:0] out_read_data;

    host_memory_port #(
        .IFM_SIZE(IFM_SIZE), .IFM_DEPTH(IFM_DEPTH),
        .KERNEL_SIZE(KERNEL_SIZE), .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) u_host (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .ifm_read_en(ifm_read_en), .ifm_read_addr(ifm_read_addr),
        .pixel(pixel), .pixel_valid(pixel_valid),
        .weight_write_en(weight_write_en), .weight_write_index(weight_write_index),
        .weight_write_data(weight_write_data),
        .bias_write_en(bias_write_en), .bias_write_index(bias_write_index),
        .bias_write_data(bias_write_data),
        .out_read_addr(out_read_addr), .out_read_data(out_read_data),
        .start(start), .busy(busy)
    );

    conv_control #(
        .IFM_SIZE(IFM_SIZE), .IFM_DEPTH(IFM_DEPTH),
        .KERNEL_SIZE(KERNEL_SIZE), .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) u_control (
        .clk(clk), .reset(reset), .start(start), .busy(busy),
        .ifm_read_en(ifm_read_en), .ifm_read_addr(ifm_read_addr),
        .window_valid(), .filter_index(filter_index),
        .channel_index(channel_index),
        .out_write_en(out_write_en), .out_write_addr(out_write_addr),
        .out_accumulate(out_accumulate), .out_relu(out_relu)
    );

    line_window #(
        .IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)
    ) u_window (
        .clk(clk), .reset(reset), .pixel_valid(pixel_valid),
        .pixel(pixel), .window(window)
    );

    conv_mac #(
        .IFM_DEPTH(IFM_DEPTH), .KERNEL_SIZE(KERNEL_SIZE),
        .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) u_mac (
        .clk(clk), .reset(reset),
        .weight_write_en(weight_write_en), .weight_write_index(weight_write_index),
        .weight_write_data(weight_write_data),
        .window(window), .filter_index(filter_index),
        .channel_index(channel_index), .sum(sum)
    );

    psum_buffer #(
        .IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE),
        .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) u_psum (
        .clk(clk), .reset(reset),
        .bias_write_en(bias_write_en), .bias_write_index(bias_write_index),
        .bias_write_data(bias_write_data),
        .out_write_en(out_write_en), .out_write_addr(out_write_addr),
        .out_accumulate(out_accumulate), .out_relu(out_relu), .sum(sum),
        .read_addr(out_read_addr), .read_data(out_read_data)
    );

endmodule

// ==== conv_mac.sv ====
`timescale 1ns/1ps

module conv_mac #(
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int WIN     = KERNEL_SIZE * KERNEL_SIZE,
    localparam int W_COUNT = NUMBER_OF_FILTERS * IFM_DEPTH * WIN,
    localparam int W_IDX_W = $clog2(W_COUNT),
    localparam int FILT_W  = $clog2(NUMBER_OF_FILTERS),
    localparam int CH_W    = $clog2(IFM_DEPTH),
    localparam int DW      = conv_pkg::DATA_WIDTH,
    localparam int ACC     = conv_pkg::ACC_WIDTH
)(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   weight_write_en,
    input  logic [W_IDX_W-1:0]     weight_write_index,
    input  logic [DW-1:0]          weight_write_data,
    input  logic [WIN*DW-1:0]      window,
    input  logic [FILT_W-1:0]      filter_index,
    input  logic [CH_W-1:0]        channel_index,
    output logic signed [ACC-1:0]  sum
);

    logic signed [DW-1:0] weights [W_COUNT];  // filter, channel, row, col
    logic signed [2*DW-1:0] prod [WIN];
    logic signed [ACC-1:0] total;
    logic [W_IDX_W-1:0] base;

    always_ff @(posedge clk)
    begin
        if (weight_write_en)
            weights[weight_write_index] <= weight_write_data;
    end

    assign base = W_IDX_W'((filter_index * IFM_DEPTH + channel_index) * WIN);

    // stage one, products
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < WIN; i++)
                prod[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < WIN; i++)
                prod[i] <= $signed(window[i*DW +: DW]) * weights[base + W_IDX_W'(i)];
        end
    end

    always_comb
    begin
        total = '0;
        for (int i = 0; i < WIN; i++)
            total = total + prod[i];  // sign extended
    end

    // stage two, adder tree result
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            sum <= '0;
        else
            sum <= total;
    end

endmodule

// ==== conv_pkg.sv ====
package conv_pkg;

    // data path widths
    localparam int DATA_WIDTH = 8;   // pixels and weights, signed
    localparam int ACC_WIDTH  = 20;  // sums and output words, signed

    localparam int WB_WIDTH      = 32;
    localparam int WB_ADDR_WIDTH = 12;  // word address

    // region code in the top three address bits
    localparam logic [2:0] REGION_CTRL   = 3'd0;
    localparam logic [2:0] REGION_IFM    = 3'd1;
    localparam logic [2:0] REGION_WEIGHT = 3'd2;
    localparam logic [2:0] REGION_BIAS   = 3'd3;
    localparam logic [2:0] REGION_OUT    = 3'd4;

    // control word
    localparam int CTRL_START_BIT = 0;  // write 1 to run
    localparam int CTRL_DONE_BIT  = 1;  // reads 1 while idle

endpackage

// ==== host_memory_port.sv ====
`timescale 1ns/1ps

module host_memory_port #(
    parameter int IFM_SIZE          = 6,
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int IFM_WORDS = IFM_DEPTH * IFM_SIZE * IFM_SIZE,
    localparam int IFM_AW    = $clog2(IFM_WORDS),
    localparam int W_COUNT   = NUMBER_OF_FILTERS * IFM_DEPTH * KERNEL_SIZE * KERNEL_SIZE,
    localparam int W_IDX_W   = $clog2(W_COUNT),
    localparam int FILT_W    = $clog2(NUMBER_OF_FILTERS),
    localparam int OUT_SIZE  = IFM_SIZE - KERNEL_SIZE + 1,
    localparam int OUT_AW    = $clog2(NUMBER_OF_FILTERS * OUT_SIZE * OUT_SIZE),
    localparam int AW        = conv_pkg::WB_ADDR_WIDTH,
    localparam int WW        = conv_pkg::WB_WIDTH,
    localparam int DW        = conv_pkg::DATA_WIDTH,
    localparam int ACC       = conv_pkg::ACC_WIDTH
)(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [AW-1:0]         wb_adr,
    input  logic [WW-1:0]         wb_dat_w,
    input  logic [WW/8-1:0]       wb_sel,
    output logic [WW-1:0]         wb_dat_r,
    output logic                  wb_ack,
    input  logic                  ifm_read_en,
    input  logic [IFM_AW-1:0]     ifm_read_addr,
    output logic [DW-1:0]         pixel,
    output logic                  pixel_valid,
    output logic                  weight_write_en,
    output logic [W_IDX_W-1:0]    weight_write_index,
    output logic [DW-1:0]         weight_write_data,
    output logic                  bias_write_en,
    output logic [FILT_W-1:0]     bias_write_index,
    output logic [ACC-1:0]        bias_write_data,
    output logic [OUT_AW-1:0]     out_read_addr,
    input  logic signed [ACC-1:0] out_read_data,
    output logic                  start,
    input  logic                  busy
);

    logic [2:0] region;
    logic [2:0] read_region;
    logic [AW-4:0] index;
    logic req;
    logic wr;
    logic signed [DW-1:0] ifm_ram [IFM_WORDS];       // channel, row, col
    logic signed [DW-1:0] weight_copy [W_COUNT];     // read-back copy of the MAC weights
    logic [WW-1:0] read_word;

    assign region = wb_adr[AW-1 -: 3];
    assign index  = wb_adr[AW-4:0];
    assign req    = wb_cyc && wb_stb && !wb_ack;  // first cycle of an access
    assign wr     = req && wb_we && (|wb_sel);

    assign weight_write_en    = wr && region == conv_pkg::REGION_WEIGHT;
    assign weight_write_index = index[W_IDX_W-1:0];
    assign weight_write_data  = wb_dat_w[DW-1:0];
    assign bias_write_en      = wr && region == conv_pkg::REGION_BIAS;
    assign bias_write_index   = index[FILT_W-1:0];
    assign bias_write_data    = wb_dat_w[ACC-1:0];
    assign out_read_addr      = index[OUT_AW-1:0];

    always_ff @(posedge clk)
    begin
        if (wr && region == conv_pkg::REGION_IFM)
            ifm_ram[index[IFM_AW-1:0]] <= wb_dat_w[DW-1:0];
        if (weight_write_en)
            weight_copy[weight_write_index] <= weight_write_data;
        if (ifm_read_en)
            pixel <= ifm_ram[ifm_read_addr];
        if (req && !wb_we)
        begin
            read_region <= region;
            case (region)
                conv_pkg::REGION_CTRL:
                begin
                    read_word <= '0;
                    read_word[conv_pkg::CTRL_DONE_BIT] <= !busy;
                end
                conv_pkg::REGION_IFM:
                    read_word <= WW'(ifm_ram[index[IFM_AW-1:0]]);
                conv_pkg::REGION_WEIGHT:
                    read_word <= WW'(weight_copy[index[W_IDX_W-1:0]]);
                default:
                    read_word <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wb_ack      <= 1'b0;
            start       <= 1'b0;
            pixel_valid <= 1'b0;
        end
        else
        begin
            wb_ack      <= req;
            start       <= wr && region == conv_pkg::REGION_CTRL
                           && wb_dat_w[conv_pkg::CTRL_START_BIT];
            pixel_valid <= ifm_read_en;
        end
    end

    // output words come straight from the buffer's read register
    assign wb_dat_r = (read_region == conv_pkg::REGION_OUT) ? WW'(out_read_data) : read_word;

    ////////////////////////////////////////////////////////////
    // bus checks
    ////////////////////////////////////////////////////////////
    a_ack_with_stb: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_stb);
    a_ifm_write_idle: assert property (@(posedge clk) disable iff (reset)
        wr && region == conv_pkg::REGION_IFM |-> !busy);

endmodule

// ==== line_window.sv ====
`timescale 1ns/1ps

module line_window #(
    parameter int IFM_SIZE    = 6,
    parameter int KERNEL_SIZE = 3,
    localparam int FIFO_SIZE = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE,
    localparam int DW        = conv_pkg::DATA_WIDTH
)(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pixel_valid,
    input  logic [DW-1:0]                       pixel,
    output logic [KERNEL_SIZE*KERNEL_SIZE*DW-1:0] window
);

    // incoming pixel is the newest line entry, taps hold the rest
    logic [DW-1:0] taps [FIFO_SIZE-1];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < FIFO_SIZE - 1; i++)
                taps[i] <= '0;
        end
        else if (pixel_valid)
        begin
            taps[0] <= pixel;
            for (int i = 1; i < FIFO_SIZE - 1; i++)
                taps[i] <= taps[i-1];
        end
    end

    // row r sits (K-1-r) image lines back
    for (genvar r = 0; r < KERNEL_SIZE; r++)
    begin : g_row
        for (genvar c = 0; c < KERNEL_SIZE; c++)
        begin : g_col
            localparam int DIST = (KERNEL_SIZE - 1 - r) * IFM_SIZE + (KERNEL_SIZE - 1 - c);
            if (DIST == 0)
            begin : g_new
                assign window[(r*KERNEL_SIZE+c)*DW +: DW] = pixel;
            end
            else
            begin : g_old
                assign window[(r*KERNEL_SIZE+c)*DW +: DW] = taps[DIST-1];
            end
        end
    end

endmodule

// ==== psum_buffer.sv ====
`timescale 1ns/1ps

module psum_buffer #(
    parameter int IFM_SIZE          = 6,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int OUT_SIZE = IFM_SIZE - KERNEL_SIZE + 1,
    localparam int MAP      = OUT_SIZE * OUT_SIZE,
    localparam int OUT_AW   = $clog2(NUMBER_OF_FILTERS * MAP),
    localparam int FILT_W   = $clog2(NUMBER_OF_FILTERS),
    localparam int ACC      = conv_pkg::ACC_WIDTH
)(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bias_write_en,
    input  logic [FILT_W-1:0]     bias_write_index,
    input  logic [ACC-1:0]        bias_write_data,
    input  logic                  out_write_en,
    input  logic [OUT_AW-1:0]     out_write_addr,
    input  logic                  out_accumulate,
    input  logic                  out_relu,
    input  logic signed [ACC-1:0] sum,
    input  logic [OUT_AW-1:0]     read_addr,
    output logic signed [ACC-1:0] read_data
);

    logic signed [ACC-1:0] bias [NUMBER_OF_FILTERS];
    logic signed [ACC-1:0] out_map [NUMBER_OF_FILTERS*MAP];  // filter, row, col
    logic signed [ACC-1:0] base;
    logic signed [ACC-1:0] result;

    always_comb
    begin
        base   = out_accumulate ? out_map[out_write_addr] : bias[FILT_W'(out_write_addr / MAP)];
        result = base + sum;
        if (out_relu && result < 0)
            result = '0;
    end

    always_ff @(posedge clk)
    begin
        if (bias_write_en)
            bias[bias_write_index] <= bias_write_data;
        if (out_write_en)
            out_map[out_write_addr] <= result;
    end

    // host read, one cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            read_data <= '0;
        else
            read_data <= out_map[read_addr];
    end

    a_addr_range: assert property (@(posedge clk) disable iff (reset)
        out_write_en |-> out_write_addr < NUMBER_OF_FILTERS * MAP);

endmodule

// ==== tb_conv_tests.svh ====
task automatic reset_status();
    int status;
    read_word(conv_pkg::REGION_CTRL, 0, status);
    check_value("reset done bit", 1, int'(status[conv_pkg::CTRL_DONE_BIT]));
endtask

task automatic load_readback();
    int value;
    for (int i = 0; i < IFM_WORDS; i++)
    begin
        ifm_model[i] = random_byte();
        write_word(conv_pkg::REGION_IFM, i, ifm_model[i]);
    end
    for (int i = 0; i < W_COUNT; i++)
    begin
        weight_model[i] = random_byte();
        write_word(conv_pkg::REGION_WEIGHT, i, weight_model[i]);
    end
    for (int i = 0; i < IFM_WORDS; i++)
    begin
        read_word(conv_pkg::REGION_IFM, i, value);
        check_value($sformatf("ifm readback %0d", i), ifm_model[i], value);
    end
    for (int i = 0; i < W_COUNT; i++)
    begin
        read_word(conv_pkg::REGION_WEIGHT, i, value);
        check_value($sformatf("weight readback %0d", i), weight_model[i], value);
    end
endtask

// compares every output with the model
task automatic check_outputs(input string name);
    int value;
    for (int f = 0; f < NUMBER_OF_FILTERS; f++)
        for (int r = 0; r < OUT_SIZE; r++)
            for (int c = 0; c < OUT_SIZE; c++)
            begin
                read_word(conv_pkg::REGION_OUT, out_index(f, r, c), value);
                check_value($sformatf("%s f%0d r%0d c%0d", name, f, r, c),
                            conv_reference(f, r, c, 1'b1), value);
            end
endtask

task automatic random_data_run();
    for (int f = 0; f < NUMBER_OF_FILTERS; f++)
    begin
        bias_model[f] = int'($urandom_range(4000)) - 2000;
        write_word(conv_pkg::REGION_BIAS, f, bias_model[f]);
    end
    run_layer();
    check_outputs("random run");
endtask

// channel 0 must overwrite the last run instead of adding onto it
task automatic repeat_run();
    run_layer();
    check_outputs("repeat run");
endtask

task automatic bias_change();
    bias_model[0] = bias_model[0] + 1500;
    write_word(conv_pkg::REGION_BIAS, 0, bias_model[0]);
    run_layer();
    check_outputs("bias change");
endtask

task automatic relu_clamp();
    int value;
    int raw;
    int negatives;
    negatives = 0;
    for (int f = 0; f < NUMBER_OF_FILTERS; f++)
    begin
        bias_model[f] = -100000 - int'($urandom_range(1000));
        write_word(conv_pkg::REGION_BIAS, f, bias_model[f]);
    end
    run_layer();
    for (int f = 0; f < NUMBER_OF_FILTERS; f++)
        for (int r = 0; r < OUT_SIZE; r++)
            for (int c = 0; c < OUT_SIZE; c++)
            begin
                raw = conv_reference(f, r, c, 1'b0);
                read_word(conv_pkg::REGION_OUT, out_index(f, r, c), value);
                if (raw < 0)
                    negatives++;
                check_value($sformatf("relu f%0d r%0d c%0d", f, r, c),
                            (raw < 0) ? 0 : raw, value);
            end
    if (negatives == 0)
    begin
        errors++;
        $display("ReLU test had no negative sums, so clamping was never exercised");
    end
endtask

// ==== tb_conv_layer.sv ====
`timescale 1ns/1ps

module tb_conv_layer;

    localparam int IFM_SIZE          = 6;
    localparam int IFM_DEPTH         = 2;
    localparam int KERNEL_SIZE       = 3;
    localparam int NUMBER_OF_FILTERS = 2;
    localparam int OUT_SIZE  = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int PIX       = IFM_SIZE * IFM_SIZE;
    localparam int IFM_WORDS = IFM_DEPTH * PIX;
    localparam int W_COUNT   = NUMBER_OF_FILTERS * IFM_DEPTH * KERNEL_SIZE * KERNEL_SIZE;
    localparam int OUT_WORDS = NUMBER_OF_FILTERS * OUT_SIZE * OUT_SIZE;
    localparam int AW        = conv_pkg::WB_ADDR_WIDTH;
    localparam int WW        = conv_pkg::WB_WIDTH;

    // watchdog budget in clock cycles with polls counted as accesses
    localparam int RUNS        = 4;
    localparam int RUN_CYCLES  = RUNS * IFM_DEPTH * NUMBER_OF_FILTERS * (PIX + 1);
    localparam int WB_ACCESSES = 1 + 2 * (IFM_WORDS + W_COUNT)
                                 + RUNS * (NUMBER_OF_FILTERS + 1 + OUT_WORDS) + RUN_CYCLES / 3;
    localparam int WATCHDOG_CYCLES = 4 * (WB_ACCESSES * 4 + RUN_CYCLES);

    logic          clk;
    logic          reset;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [AW-1:0] wb_adr;
    logic [WW-1:0] wb_dat_w;
    logic [WW/8-1:0] wb_sel;
    logic [WW-1:0] wb_dat_r;
    logic          wb_ack;

    int ifm_model [IFM_WORDS];      // channel, row, col
    int weight_model [W_COUNT];     // filter, channel, row, col
    int bias_model [NUMBER_OF_FILTERS];
    int errors;
    int checks;

    conv_layer_top #(
        .IFM_SIZE(IFM_SIZE), .IFM_DEPTH(IFM_DEPTH),
        .KERNEL_SIZE(KERNEL_SIZE), .NUMBER_OF_FILTERS(NUMBER_OF_FILTERS)
    ) DUT (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial
        clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // wishbone access
    ////////////////////////////////////////////////////////////
    task automatic wait_ack();
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
    endtask

    task automatic end_access();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_word(input logic [2:0] region, input int index, input int data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= {region, (AW-3)'(index)};
        wb_dat_w <= WW'(data);
        wb_sel   <= '1;
        wait_ack();
        end_access();
    endtask

    task automatic read_word(input logic [2:0] region, input int index, output int data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= {region, (AW-3)'(index)};
        wb_sel <= '1;
        wait_ack();
        data = $signed(wb_dat_r);  // sampled while ack is high
        end_access();
    endtask

    task automatic run_layer();
        int status;
        write_word(conv_pkg::REGION_CTRL, 0, 1 << conv_pkg::CTRL_START_BIT);
        status = 0;
        while (!status[conv_pkg::CTRL_DONE_BIT])
            read_word(conv_pkg::REGION_CTRL, 0, status);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////
    function automatic int conv_reference(input int f, input int r, input int c,
                                          input bit apply_relu);
        int acc;
        acc = bias_model[f];
        for (int ch = 0; ch < IFM_DEPTH; ch++)
            for (int kr = 0; kr < KERNEL_SIZE; kr++)
                for (int kc = 0; kc < KERNEL_SIZE; kc++)
                    acc += ifm_model[ch*PIX + (r+kr)*IFM_SIZE + c + kc]
                           * weight_model[((f*IFM_DEPTH + ch)*KERNEL_SIZE + kr)*KERNEL_SIZE + kc];
        if (apply_relu && acc < 0)
            acc = 0;
        return acc;
    endfunction

    function automatic int out_index(input int f, input int r, input int c);
        return (f * OUT_SIZE + r) * OUT_SIZE + c;
    endfunction

    function automatic int random_byte();
        return int'($urandom_range(255)) - 128;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    `include "tb_conv_tests.svh"

    initial
    begin
        void'($urandom(32'hb7dc_0866));
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        reset_status();
        load_readback();
        random_data_run();
        repeat_run();
        bias_change();
        relu_clamp();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the layer did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
conv_pkg.sv
line_window.sv
conv_mac.sv
psum_buffer.sv
host_memory_port.sv
conv_control.sv
conv_layer_top.sv
tb_conv_layer.sv
